//--- run_sim.sh
#!/usr/bin/env bash
# Build the write-back subsystem testbench with Verilator, run it, and
# decide pass or fail from the simulation log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --top-module wb_tb \
    -f wb_subsys.f --Mdir "$BUILD_DIR" -o wb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/wb_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test completed successfully" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1

//--- source/csr_file.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module csr_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        we,
    input  logic [`WB_CSR_NUM_W-1:0]    wnum,
    input  logic [`WB_XLEN-1:0]         wdata,
    input  logic                        excp_flush,
    input  logic [`WB_XLEN-1:0]         excp_era,
    input  wb_pkg::excp_cause_e         ecode,
    input  logic [`WB_ESUBCODE_W-1:0]   esubcode,
    input  logic [`WB_CSR_NUM_W-1:0]    rnum,
    output logic [`WB_XLEN-1:0]         rdata
);

    logic [`WB_XLEN-1:0] crmd;
    logic [`WB_XLEN-1:0] estat;   // only ecode/esubcode live here
    logic [`WB_XLEN-1:0] era;
    logic [`WB_XLEN-1:0] save0;
    logic [`WB_XLEN-1:0] save1;
    logic [`WB_XLEN-1:0] save2;
    logic [`WB_XLEN-1:0] save3;

    // software writes at retirement, estat not writable here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd  <= `WB_CRMD_RESET;
            era   <= '0;
            save0 <= '0;
            save1 <= '0;
            save2 <= '0;
            save3 <= '0;
        end else begin
            if (we) begin
                case (wnum)
                    wb_pkg::CSR_CRMD:  crmd  <= wdata;
                    wb_pkg::CSR_ERA:   era   <= wdata;
                    wb_pkg::CSR_SAVE0: save0 <= wdata;
                    wb_pkg::CSR_SAVE1: save1 <= wdata;
                    wb_pkg::CSR_SAVE2: save2 <= wdata;
                    wb_pkg::CSR_SAVE3: save3 <= wdata;
                    default: ;  // estat and unknown numbers dropped
                endcase
            end
            // later assignment, so the flush beats a same-edge era write
            if (excp_flush)
                era <= excp_era;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            estat <= '0;
        end else if (excp_flush) begin
            estat[wb_pkg::ESTAT_ECODE_HI:wb_pkg::ESTAT_ECODE_LO]       <= ecode;
            estat[wb_pkg::ESTAT_ESUBCODE_HI:wb_pkg::ESTAT_ESUBCODE_LO] <= esubcode;
        end
    end

    // combinational read, holes read as zero
    always_comb begin
        case (rnum)
            wb_pkg::CSR_CRMD:  rdata = crmd;
            wb_pkg::CSR_ESTAT: rdata = estat;
            wb_pkg::CSR_ERA:   rdata = era;
            wb_pkg::CSR_SAVE0: rdata = save0;
            wb_pkg::CSR_SAVE1: rdata = save1;
            wb_pkg::CSR_SAVE2: rdata = save2;
            wb_pkg::CSR_SAVE3: rdata = save3;
            default:           rdata = '0;
        endcase
    end

    // stage must never flush without a decoded cause
    a_flush_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
        excp_flush |-> ecode != wb_pkg::ECODE_NONE);

endmodule

//--- source/gpr_file.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module gpr_file (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      we,
    input  logic [`WB_REG_IDX_W-1:0]  waddr,
    input  logic [`WB_XLEN-1:0]       wdata,
    input  logic [`WB_REG_IDX_W-1:0]  raddr_a,
    input  logic [`WB_REG_IDX_W-1:0]  raddr_b,
    output logic [`WB_XLEN-1:0]       rdata_a,
    output logic [`WB_XLEN-1:0]       rdata_b
);

    localparam int NUM_REGS = 1 << `WB_REG_IDX_W;

    logic [`WB_XLEN-1:0] regs [NUM_REGS];  // entry 0 never written

    // write at the edge, r0 writes dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, no internal bypass
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    // a stray write to r0 would show up here
    a_r0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (raddr_a == '0) |-> (rdata_a == '0));

endmodule

//--- source/operand_bypass.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module operand_bypass (
    input  logic [`WB_REG_IDX_W-1:0]  rj,
    input  logic [`WB_REG_IDX_W-1:0]  rk,
    input  logic [`WB_XLEN-1:0]       gpr_rdata_a,
    input  logic [`WB_XLEN-1:0]       gpr_rdata_b,
    input  logic                      fwd_in_en,
    input  logic [`WB_REG_IDX_W-1:0]  fwd_in_idx,
    input  logic [`WB_XLEN-1:0]       fwd_in_data,
    input  logic                      fwd_q_en,
    input  logic [`WB_REG_IDX_W-1:0]  fwd_q_idx,
    input  logic [`WB_XLEN-1:0]       fwd_q_data,
    input  logic [`WB_CSR_NUM_W-1:0]  csr_rnum,
    input  logic [`WB_XLEN-1:0]       csr_rdata_file,
    input  logic                      fwd_csr_in_en,
    input  logic [`WB_CSR_NUM_W-1:0]  fwd_csr_in_num,
    input  logic [`WB_XLEN-1:0]       fwd_csr_in_data,
    input  logic                      fwd_csr_q_en,
    input  logic [`WB_CSR_NUM_W-1:0]  fwd_csr_q_num,
    input  logic [`WB_XLEN-1:0]       fwd_csr_q_data,
    output logic [`WB_XLEN-1:0]       rj_data,
    output logic [`WB_XLEN-1:0]       rk_data,
    output logic [`WB_XLEN-1:0]       csr_rdata
);

    // youngest first: mem-stage input, then held copy, then file
    function automatic logic [`WB_XLEN-1:0] pick_gpr(
        input logic [`WB_REG_IDX_W-1:0] idx,
        input logic [`WB_XLEN-1:0]      stored
    );
        logic hit_in;
        logic hit_q;
        hit_in = fwd_in_en && (fwd_in_idx == idx);
        hit_q  = fwd_q_en && (fwd_q_idx == idx);
        if (idx == '0)
            return stored;  // r0, file already gives zero
        else if (hit_in)
            return fwd_in_data;
        else if (hit_q)
            return fwd_q_data;
        return stored;
    endfunction

    always_comb begin
        rj_data = pick_gpr(rj, gpr_rdata_a);
        rk_data = pick_gpr(rk, gpr_rdata_b);
    end

    // csr side, same order, csr 0 (crmd) forwards normally
    always_comb begin
        if (fwd_csr_in_en && (fwd_csr_in_num == csr_rnum))
            csr_rdata = fwd_csr_in_data;
        else if (fwd_csr_q_en && (fwd_csr_q_num == csr_rnum))
            csr_rdata = fwd_csr_q_data;
        else
            csr_rdata = csr_rdata_file;
    end

endmodule

//--- source/wb_pkg.sv
`include "wb_settings.svh"

package wb_pkg;

    // estat.ecode values raised by this stage
    typedef enum logic [`WB_ECODE_W-1:0] {
        ECODE_NONE = 6'h00,  // nothing pending
        ECODE_SYS  = 6'h0B,  // syscall
        ECODE_BRK  = 6'h0C,  // break
        ECODE_INE  = 6'h0D,  // illegal instruction
        ECODE_IPE  = 6'h0E   // privileged instruction
    } excp_cause_e;

    // csr numbers implemented in this subset
    typedef enum logic [`WB_CSR_NUM_W-1:0] {
        CSR_CRMD  = 14'h000,
        CSR_ESTAT = 14'h005,
        CSR_ERA   = 14'h006,
        CSR_SAVE0 = 14'h030,
        CSR_SAVE1 = 14'h031,
        CSR_SAVE2 = 14'h032,
        CSR_SAVE3 = 14'h033
    } csr_addr_e;

    // estat field positions
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ECODE_HI    = 21;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_HI = 30;

endpackage

//--- source/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// datapath and pc width
`define WB_XLEN 32

// gpr index, 32 entries
`define WB_REG_IDX_W 5

// csr number field of csrrd/csrwr
`define WB_CSR_NUM_W 14

// exception cause vector from mem stage
// bit 5 syscall, 6 break, 7 ine, 8 ipe
// bits 0..4 are fetch-side, not encoded here
`define WB_EXCP_W 9

// bit positions inside the cause vector
`define WB_EXCP_SYS 5
`define WB_EXCP_BRK 6
`define WB_EXCP_INE 7
`define WB_EXCP_IPE 8

// ecode and esubcode widths, matching the estat fields
`define WB_ECODE_W 6
`define WB_ESUBCODE_W 9

// crmd comes up in direct address mode, plv0
`define WB_CRMD_RESET 32'h8

`endif

//--- source/wb_stage.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         left_valid,
    input  logic                         right_ready,
    input  logic                         inst_valid,
    input  logic                         is_break,
    input  logic                         wreg_en,
    input  logic [`WB_REG_IDX_W-1:0]     wreg_index,
    input  logic [`WB_XLEN-1:0]          inst,
    input  logic [`WB_XLEN-1:0]          pc,
    input  logic [`WB_XLEN-1:0]          mem_result,
    input  logic                         csr_we,
    input  logic [`WB_CSR_NUM_W-1:0]     csr_num,
    input  logic [`WB_XLEN-1:0]          csr_wdata,
    input  logic                         ms_excp,
    input  logic [`WB_EXCP_W-1:0]        excp_num,
    output logic                         left_ready,
    output logic                         right_valid,
    output logic                         excp_flush,
    output logic [`WB_XLEN-1:0]          excp_era,
    output wb_pkg::excp_cause_e          ecode,
    output logic [`WB_ESUBCODE_W-1:0]    esubcode,
    output logic                         gpr_we,
    output logic [`WB_REG_IDX_W-1:0]     gpr_waddr,
    output logic [`WB_XLEN-1:0]          gpr_wdata,
    output logic                         csr_we_q,
    output logic [`WB_CSR_NUM_W-1:0]     csr_num_q,
    output logic [`WB_XLEN-1:0]          csr_wdata_q,
    output logic [`WB_XLEN-1:0]          commit_pc,
    output logic                         fwd_in_en,
    output logic [`WB_REG_IDX_W-1:0]     fwd_in_idx,
    output logic [`WB_XLEN-1:0]          fwd_in_data,
    output logic                         fwd_q_en,
    output logic                         fwd_csr_in_en,
    output logic [`WB_CSR_NUM_W-1:0]     fwd_csr_in_num,
    output logic [`WB_XLEN-1:0]          fwd_csr_in_data
);

    logic                      valid_q;     // pipeline register occupied
    logic                      wen_q;       // already cleared for excp / bubble
    logic [`WB_REG_IDX_W-1:0]  widx_q;
    logic [`WB_XLEN-1:0]       result_q;
    logic [`WB_XLEN-1:0]       pc_q;
    logic                      csr_we_r;
    logic [`WB_CSR_NUM_W-1:0]  csr_num_r;
    logic [`WB_XLEN-1:0]       csr_wdata_r;
    logic                      transfer;
    logic                      commit_ok;   // real inst, no exception

    assign transfer  = left_valid & right_ready;
    assign commit_ok = inst_valid & ~ms_excp;

    // flush goes out the same cycle the excepting inst shows up
    assign excp_flush = ms_excp & inst_valid & left_valid;
    assign excp_era   = pc;
    assign esubcode   = '0;  // no subcodes for these causes

    // sys > brk > ine > ipe
    always_comb begin
        if (excp_num[`WB_EXCP_SYS])
            ecode = wb_pkg::ECODE_SYS;
        else if (excp_num[`WB_EXCP_BRK] | is_break)  // decode may flag break directly
            ecode = wb_pkg::ECODE_BRK;
        else if (excp_num[`WB_EXCP_INE])
            ecode = wb_pkg::ECODE_INE;
        else if (excp_num[`WB_EXCP_IPE])
            ecode = wb_pkg::ECODE_IPE;
        else
            ecode = wb_pkg::ECODE_NONE;
    end

    // downstream ready retires the held inst, so reload or go empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (right_ready) begin
            valid_q <= left_valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wen_q       <= 1'b0;
            widx_q      <= '0;
            result_q    <= '0;
            pc_q        <= '0;
            csr_we_r    <= 1'b0;
            csr_num_r   <= '0;
            csr_wdata_r <= '0;
        end else if (transfer) begin
            wen_q       <= wreg_en & commit_ok;  // drop writes of excp/invalid
            widx_q      <= wreg_index;
            result_q    <= mem_result;
            pc_q        <= pc;
            csr_we_r    <= csr_we & commit_ok;
            csr_num_r   <= csr_num;
            csr_wdata_r <= csr_wdata;
        end
    end

    assign left_ready  = right_ready;  // single slot, no skid
    assign right_valid = valid_q;
    assign commit_pc   = pc_q;

    // gpr write only on the retiring cycle
    assign gpr_we    = valid_q & right_ready & wen_q;
    assign gpr_waddr = widx_q;
    assign gpr_wdata = result_q;

    // csr write stays up while held, it doubles as the held forward tap
    assign csr_we_q    = valid_q & csr_we_r;
    assign csr_num_q   = csr_num_r;
    assign csr_wdata_q = csr_wdata_r;

    // in-flight taps straight off the mem stage inputs
    assign fwd_in_en   = wreg_en & left_valid & commit_ok;
    assign fwd_in_idx  = wreg_index;
    assign fwd_in_data = mem_result;
    assign fwd_q_en    = valid_q & wen_q;  // held copy, valid under stall too

    assign fwd_csr_in_en   = csr_we & left_valid & commit_ok;
    assign fwd_csr_in_num  = csr_num;
    assign fwd_csr_in_data = csr_wdata;

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(right_valid) && (!right_valid || !$isunknown(pc_q)));

endmodule

//--- source/wb_top.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         left_valid,
    input  logic                         inst_valid,
    input  logic                         is_break,
    input  logic                         wreg_en,
    input  logic [`WB_REG_IDX_W-1:0]     wreg_index,
    input  logic [`WB_XLEN-1:0]          inst,
    input  logic [`WB_XLEN-1:0]          pc,
    input  logic [`WB_XLEN-1:0]          mem_result,
    input  logic                         csr_we,
    input  logic [`WB_CSR_NUM_W-1:0]     csr_num,
    input  logic [`WB_XLEN-1:0]          csr_wdata,
    input  logic                         ms_excp,
    input  logic [`WB_EXCP_W-1:0]        excp_num,
    input  logic                         right_ready,
    input  logic [`WB_REG_IDX_W-1:0]     rj,
    input  logic [`WB_REG_IDX_W-1:0]     rk,
    input  logic [`WB_CSR_NUM_W-1:0]     csr_rnum,
    output logic                         left_ready,
    output logic                         right_valid,
    output logic [`WB_XLEN-1:0]          commit_pc,
    output logic                         gpr_we,
    output logic [`WB_REG_IDX_W-1:0]     gpr_waddr,
    output logic [`WB_XLEN-1:0]          gpr_wdata,
    output logic                         excp_flush,
    output logic [`WB_XLEN-1:0]          excp_era,
    output wb_pkg::excp_cause_e          ecode,
    output logic [`WB_ESUBCODE_W-1:0]    esubcode,
    output logic [`WB_XLEN-1:0]          rj_data,
    output logic [`WB_XLEN-1:0]          rk_data,
    output logic [`WB_XLEN-1:0]          csr_rdata
);

    logic                      csr_we_q;
    logic [`WB_CSR_NUM_W-1:0]  csr_num_q;
    logic [`WB_XLEN-1:0]       csr_wdata_q;
    logic                      fwd_in_en;
    logic [`WB_REG_IDX_W-1:0]  fwd_in_idx;
    logic [`WB_XLEN-1:0]       fwd_in_data;
    logic                      fwd_q_en;
    logic                      fwd_csr_in_en;
    logic [`WB_CSR_NUM_W-1:0]  fwd_csr_in_num;
    logic [`WB_XLEN-1:0]       fwd_csr_in_data;
    logic [`WB_XLEN-1:0]       gpr_rdata_a;   // raw file reads
    logic [`WB_XLEN-1:0]       gpr_rdata_b;
    logic [`WB_XLEN-1:0]       csr_rdata_file;

    wb_stage wb_stage_i (
        .clk, .rst_n, .left_valid, .right_ready, .inst_valid, .is_break,
        .wreg_en, .wreg_index, .inst, .pc, .mem_result,
        .csr_we, .csr_num, .csr_wdata, .ms_excp, .excp_num,
        .left_ready, .right_valid,
        .excp_flush, .excp_era, .ecode, .esubcode,
        .gpr_we, .gpr_waddr, .gpr_wdata,
        .csr_we_q, .csr_num_q, .csr_wdata_q, .commit_pc,
        .fwd_in_en, .fwd_in_idx, .fwd_in_data, .fwd_q_en,
        .fwd_csr_in_en, .fwd_csr_in_num, .fwd_csr_in_data
    );

    gpr_file gpr_file_i (
        .clk, .rst_n,
        .we      (gpr_we),
        .waddr   (gpr_waddr),
        .wdata   (gpr_wdata),
        .raddr_a (rj),
        .raddr_b (rk),
        .rdata_a (gpr_rdata_a),
        .rdata_b (gpr_rdata_b)
    );

    csr_file csr_file_i (
        .clk, .rst_n,
        .we    (csr_we_q),
        .wnum  (csr_num_q),
        .wdata (csr_wdata_q),
        .excp_flush, .excp_era, .ecode, .esubcode,
        .rnum  (csr_rnum),
        .rdata (csr_rdata_file)
    );

    // held taps are the pipeline register outputs themselves
    operand_bypass operand_bypass_i (
        .rj, .rk, .gpr_rdata_a, .gpr_rdata_b,
        .fwd_in_en, .fwd_in_idx, .fwd_in_data,
        .fwd_q_en,
        .fwd_q_idx       (gpr_waddr),
        .fwd_q_data      (gpr_wdata),
        .csr_rnum, .csr_rdata_file,
        .fwd_csr_in_en, .fwd_csr_in_num, .fwd_csr_in_data,
        .fwd_csr_q_en    (csr_we_q),
        .fwd_csr_q_num   (csr_num_q),
        .fwd_csr_q_data  (csr_wdata_q),
        .rj_data, .rk_data, .csr_rdata
    );

endmodule

//--- tests/wb_checker.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    // memory-stage side, as the tb drives it
    input  logic                        left_valid,
    input  logic                        right_ready,
    input  logic                        inst_valid,
    input  logic                        wreg_en,
    input  logic [`WB_REG_IDX_W-1:0]    wreg_index,
    input  logic [`WB_XLEN-1:0]         pc,
    input  logic [`WB_XLEN-1:0]         mem_result,
    input  logic                        csr_we,
    input  logic [`WB_CSR_NUM_W-1:0]    csr_num,
    input  logic [`WB_XLEN-1:0]         csr_wdata,
    input  logic                        ms_excp,
    input  logic [`WB_EXCP_W-1:0]       excp_num,
    input  logic [`WB_REG_IDX_W-1:0]    rj,
    input  logic [`WB_REG_IDX_W-1:0]    rk,
    input  logic [`WB_CSR_NUM_W-1:0]    csr_rnum,
    // dut outputs under check
    input  logic                        left_ready,
    input  logic                        right_valid,
    input  logic [`WB_XLEN-1:0]         commit_pc,
    input  logic                        gpr_we,
    input  logic [`WB_REG_IDX_W-1:0]    gpr_waddr,
    input  logic [`WB_XLEN-1:0]         gpr_wdata,
    input  logic                        excp_flush,
    input  logic [`WB_XLEN-1:0]         excp_era,
    input  wb_pkg::excp_cause_e         ecode,
    input  logic [`WB_ESUBCODE_W-1:0]   esubcode,
    input  logic [`WB_XLEN-1:0]         rj_data,
    input  logic [`WB_XLEN-1:0]         rk_data,
    input  logic [`WB_XLEN-1:0]         csr_rdata
);

    int unsigned error_count = 0;
    int unsigned retire_count = 0;
    int unsigned flush_count = 0;

    // reference pipeline register
    logic                       m_valid;
    logic                       m_wen;        // already cleared for excp / invalid
    logic [`WB_REG_IDX_W-1:0]   m_widx;
    logic [`WB_XLEN-1:0]        m_result;
    logic [`WB_XLEN-1:0]        m_pc;
    logic                       m_csr_we;
    logic [`WB_CSR_NUM_W-1:0]   m_csr_num;
    logic [`WB_XLEN-1:0]        m_csr_wdata;

    // reference architectural state
    logic [`WB_XLEN-1:0]        m_gpr [32];
    logic [`WB_XLEN-1:0]        m_crmd;
    logic [`WB_XLEN-1:0]        m_estat;
    logic [`WB_XLEN-1:0]        m_era;
    logic [`WB_XLEN-1:0]        m_save [4];

    logic in_ok;       // incoming inst is real and clean
    logic flush_exp;

    assign in_ok     = left_valid && inst_valid && !ms_excp;
    assign flush_exp = ms_excp && inst_valid && left_valid;

    // sys > brk > ine > ipe
    function automatic wb_pkg::excp_cause_e expect_ecode(input logic [`WB_EXCP_W-1:0] causes);
        if (causes[`WB_EXCP_SYS])
            return wb_pkg::ECODE_SYS;
        if (causes[`WB_EXCP_BRK])
            return wb_pkg::ECODE_BRK;
        if (causes[`WB_EXCP_INE])
            return wb_pkg::ECODE_INE;
        if (causes[`WB_EXCP_IPE])
            return wb_pkg::ECODE_IPE;
        return wb_pkg::ECODE_NONE;
    endfunction

    function automatic logic [`WB_XLEN-1:0] csr_stored(input logic [`WB_CSR_NUM_W-1:0] num);
        case (num)
            wb_pkg::CSR_CRMD:  return m_crmd;
            wb_pkg::CSR_ESTAT: return m_estat;
            wb_pkg::CSR_ERA:   return m_era;
            wb_pkg::CSR_SAVE0: return m_save[0];
            wb_pkg::CSR_SAVE1: return m_save[1];
            wb_pkg::CSR_SAVE2: return m_save[2];
            wb_pkg::CSR_SAVE3: return m_save[3];
            default:           return '0;  // holes read zero
        endcase
    endfunction

    // youngest uncommitted value wins
    function automatic logic [`WB_XLEN-1:0] gpr_expect(input logic [`WB_REG_IDX_W-1:0] idx);
        if (idx == '0)
            return '0;
        if (in_ok && wreg_en && wreg_index == idx)
            return mem_result;
        if (m_valid && m_wen && m_widx == idx)
            return m_result;
        return m_gpr[idx];
    endfunction

    function automatic logic [`WB_XLEN-1:0] csr_expect(input logic [`WB_CSR_NUM_W-1:0] num);
        if (in_ok && csr_we && csr_num == num)
            return csr_wdata;
        if (m_valid && m_csr_we && m_csr_num == num)
            return m_csr_wdata;
        return csr_stored(num);
    endfunction

    task automatic compare(input string name, input logic [`WB_XLEN-1:0] expected,
                           input logic [`WB_XLEN-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s expected 0x%h actual 0x%h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic write_csr(input logic [`WB_CSR_NUM_W-1:0] num, input logic [`WB_XLEN-1:0] data);
        case (num)
            wb_pkg::CSR_CRMD:  m_crmd = data;
            wb_pkg::CSR_ERA:   m_era = data;
            wb_pkg::CSR_SAVE0: m_save[0] = data;
            wb_pkg::CSR_SAVE1: m_save[1] = data;
            wb_pkg::CSR_SAVE2: m_save[2] = data;
            wb_pkg::CSR_SAVE3: m_save[3] = data;
            default: ;  // estat read-only, unknown numbers dropped
        endcase
    endtask

    task automatic reset_model();
        int i;
        m_valid     = 1'b0;
        m_wen       = 1'b0;
        m_widx      = '0;
        m_result    = '0;
        m_pc        = '0;
        m_csr_we    = 1'b0;
        m_csr_num   = '0;
        m_csr_wdata = '0;
        for (i = 0; i < 32; i++)
            m_gpr[i] = '0;
        for (i = 0; i < 4; i++)
            m_save[i] = '0;
        m_crmd  = `WB_CRMD_RESET;
        m_estat = '0;
        m_era   = '0;
    endtask

    // one clock edge of the reference
    task automatic step_model();
        if (m_valid && right_ready) begin
            retire_count++;
            if (m_wen && m_widx != '0)
                m_gpr[m_widx] = m_result;
            if (m_csr_we)
                write_csr(m_csr_num, m_csr_wdata);
        end
        // after the write, so a same-edge era write loses
        if (flush_exp) begin
            flush_count++;
            m_era          = pc;
            m_estat[21:16] = expect_ecode(excp_num);
            m_estat[30:22] = '0;
        end
        if (right_ready)
            m_valid = left_valid;
        if (left_valid && right_ready) begin
            m_wen       = wreg_en && inst_valid && !ms_excp;
            m_widx      = wreg_index;
            m_result    = mem_result;
            m_pc        = pc;
            m_csr_we    = csr_we && inst_valid && !ms_excp;
            m_csr_num   = csr_num;
            m_csr_wdata = csr_wdata;
        end
    endtask

    task automatic check_outputs();
        compare("left_ready", 32'(right_ready), 32'(left_ready));
        compare("right_valid", 32'(m_valid), 32'(right_valid));
        compare("commit_pc", m_pc, commit_pc);
        compare("gpr_waddr", 32'(m_widx), 32'(gpr_waddr));
        compare("gpr_wdata", m_result, gpr_wdata);
        compare("gpr_we", 32'(m_valid && right_ready && m_wen), 32'(gpr_we));
        compare("excp_flush", 32'(flush_exp), 32'(excp_flush));
        compare("ecode", 32'(expect_ecode(excp_num)), 32'(ecode));
        compare("esubcode", 0, 32'(esubcode));
        if (flush_exp)
            compare("excp_era", pc, excp_era);
        compare("rj_data", gpr_expect(rj), rj_data);
        compare("rk_data", gpr_expect(rk), rk_data);
        compare("csr_rdata", csr_expect(csr_rnum), csr_rdata);
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            reset_model();
        else
            step_model();
    end

    // inputs change on the falling edge, look a bit later
    always begin
        @(negedge clk);
        #2;
        if (rst_n)
            check_outputs();
    end

endmodule

//--- tests/wb_tb.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_tb;

    localparam int NUM_RETIRE     = 2000;   // retirements before wind-down
    localparam int RETIRE_TIMEOUT = 20000;  // cycles
    localparam int DRAIN_TIMEOUT  = 200;

    logic                        clk;
    logic                        rst_n;
    logic                        left_valid;
    logic                        inst_valid;
    logic                        is_break;
    logic                        wreg_en;
    logic [`WB_REG_IDX_W-1:0]    wreg_index;
    logic [`WB_XLEN-1:0]         inst;
    logic [`WB_XLEN-1:0]         pc;
    logic [`WB_XLEN-1:0]         mem_result;
    logic                        csr_we;
    logic [`WB_CSR_NUM_W-1:0]    csr_num;
    logic [`WB_XLEN-1:0]         csr_wdata;
    logic                        ms_excp;
    logic [`WB_EXCP_W-1:0]       excp_num;
    logic                        right_ready;
    logic [`WB_REG_IDX_W-1:0]    rj;
    logic [`WB_REG_IDX_W-1:0]    rk;
    logic [`WB_CSR_NUM_W-1:0]    csr_rnum;
    logic                        left_ready;
    logic                        right_valid;
    logic [`WB_XLEN-1:0]         commit_pc;
    logic                        gpr_we;
    logic [`WB_REG_IDX_W-1:0]    gpr_waddr;
    logic [`WB_XLEN-1:0]         gpr_wdata;
    logic                        excp_flush;
    logic [`WB_XLEN-1:0]         excp_era;
    wb_pkg::excp_cause_e         ecode;
    logic [`WB_ESUBCODE_W-1:0]   esubcode;
    logic [`WB_XLEN-1:0]         rj_data;
    logic [`WB_XLEN-1:0]         rk_data;
    logic [`WB_XLEN-1:0]         csr_rdata;

    int unsigned timeout_count;
    int          cycles;

    wb_top dut_i (.*);

    wb_checker chk_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // mostly r0..r7 so reads hit recent writes
    function automatic logic [`WB_REG_IDX_W-1:0] pick_reg();
        logic [31:0] r;
        r = $urandom;
        if (r[7:5] == 3'b000)
            return r[`WB_REG_IDX_W-1:0];
        return {2'b00, r[2:0]};
    endfunction

    function automatic logic [`WB_CSR_NUM_W-1:0] pick_csr();
        case ($urandom_range(7))
            0: return wb_pkg::CSR_CRMD;
            1: return wb_pkg::CSR_ESTAT;
            2: return wb_pkg::CSR_ERA;
            3: return wb_pkg::CSR_SAVE0;
            4: return wb_pkg::CSR_SAVE1;
            5: return wb_pkg::CSR_SAVE2;
            6: return wb_pkg::CSR_SAVE3;
            default: return 14'h001;  // not implemented
        endcase
    endfunction

    // quiet bus, downstream ready
    task automatic set_idle();
        left_valid  = 1'b0;
        right_ready = 1'b1;
        inst_valid  = 1'b0;
        is_break    = 1'b0;
        wreg_en     = 1'b0;
        wreg_index  = '0;
        inst        = '0;
        pc          = '0;
        mem_result  = '0;
        csr_we      = 1'b0;
        csr_num     = '0;
        csr_wdata   = '0;
        ms_excp     = 1'b0;
        excp_num    = '0;
        rj          = '0;
        rk          = '0;
        csr_rnum    = '0;
    endtask

    task automatic drive_random();
        logic [31:0]            r;
        logic [`WB_EXCP_W-1:0]  causes;
        r = $urandom;
        left_valid  = (r[1:0] != 2'b00);
        right_ready = (r[3:2] != 2'b00);   // low about a quarter of the time
        inst_valid  = (r[6:4] != 3'b000);
        wreg_en     = (r[8:7] != 2'b00);
        csr_we      = (r[11:9] == 3'b000);
        ms_excp     = (r[15:12] == 4'h0);  // rare
        causes      = '0;
        if (ms_excp) begin
            causes = r[24:16];
            // a flush always carries at least one encodable cause
            case (r[26:25])
                2'd0: causes[`WB_EXCP_SYS] = 1'b1;
                2'd1: causes[`WB_EXCP_BRK] = 1'b1;
                2'd2: causes[`WB_EXCP_INE] = 1'b1;
                default: causes[`WB_EXCP_IPE] = 1'b1;
            endcase
        end else if (r[31:29] == 3'b000) begin
            causes = r[24:16];  // stray bits without ms_excp
        end
        excp_num   = causes;
        is_break   = causes[`WB_EXCP_BRK];
        wreg_index = pick_reg();
        inst       = $urandom;
        pc         = $urandom & 32'hFFFF_FFFC;
        mem_result = $urandom;
        csr_num    = pick_csr();
        csr_wdata  = $urandom;
        rj         = pick_reg();
        rk         = pick_reg();
        csr_rnum   = pick_csr();
    endtask

    initial begin
        void'($urandom(34768));
        timeout_count = 0;
        rst_n = 1'b0;
        set_idle();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // random traffic until enough instructions have retired
        cycles = 0;
        while (chk_i.retire_count < NUM_RETIRE && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            drive_random();
            cycles++;
        end
        if (chk_i.retire_count < NUM_RETIRE) begin
            timeout_count++;
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     chk_i.retire_count, NUM_RETIRE, RETIRE_TIMEOUT);
        end

        // let the pipeline register empty
        @(negedge clk);
        set_idle();
        cycles = 0;
        while (right_valid && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (right_valid) begin
            timeout_count++;
            $display("timeout: pipeline register still holds an instruction after drain");
        end
        repeat (2) @(negedge clk);

        $display("retired %0d, flushes %0d, mismatches %0d, timeouts %0d",
                 chk_i.retire_count, chk_i.flush_count, chk_i.error_count, timeout_count);
        if (chk_i.error_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- wb_subsys.f
+incdir+source
source/wb_pkg.sv
source/wb_stage.sv
source/gpr_file.sv
source/csr_file.sv
source/operand_bypass.sv
source/wb_top.sv
tests/wb_checker.sv
tests/wb_tb.sv
